/* build.f */
+incdir+hw
hw/geom_pkg.sv
hw/bus_pkg.sv
hw/aste_table.sv
hw/sweep_fetch.sv
hw/move_stage.sv
hw/collide_stage.sv
hw/wb_field_port.sv
hw/aste_field_top.sv
verification/field_model.sv
verification/tb_aste_field.sv

/* hw/aste_field_top.sv */
`default_nettype none

module aste_field_top (
    input  wire                   clock,
    input  wire                   rst,
    input  wire bus_pkg::wb_req_t wb_req,
    output bus_pkg::wb_rsp_t      wb_rsp
);
    import geom_pkg::*;

    entry_idx_t  host_addr;
    logic        host_we;
    aste_entry_t host_wdata;
    aste_entry_t host_rdata;
    logic        start;
    ship_pos_t   ship_pos;
    logic        busy;
    logic        done;
    hit_count_t  hits;
    entry_idx_t  rd_idx;
    aste_entry_t rd_entry;
    stage_item_t fetch_item;
    stage_item_t move_item;
    logic        wb_en;
    entry_idx_t  wb_idx;
    aste_entry_t wb_entry;

    wb_field_port u_wb_field_port (
        .clock      (clock),
        .rst        (rst),
        .wb_req     (wb_req),
        .host_rdata (host_rdata),
        .busy       (busy),
        .done       (done),
        .hits       (hits),
        .wb_rsp     (wb_rsp),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .start      (start),
        .ship_pos   (ship_pos)
    );

    aste_table u_aste_table (
        .clock      (clock),
        .host_addr  (host_addr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .rd_idx     (rd_idx),
        .wb_en      (wb_en),
        .wb_idx     (wb_idx),
        .wb_entry   (wb_entry),
        .host_rdata (host_rdata),
        .rd_entry   (rd_entry)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sweep pipeline.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    sweep_fetch u_sweep_fetch (
        .clock      (clock),
        .rst        (rst),
        .start      (start),
        .rd_idx     (rd_idx),
        .fetch_item (fetch_item),
        .busy       (busy),
        .done       (done)
    );

    move_stage u_move_stage (
        .clock    (clock),
        .rst      (rst),
        .in_item  (fetch_item),
        .in_entry (rd_entry),
        .out_item (move_item)
    );

    collide_stage u_collide_stage (
        .clock    (clock),
        .rst      (rst),
        .start    (start),
        .in_item  (move_item),
        .ship_pos (ship_pos),
        .wb_en    (wb_en),
        .wb_idx   (wb_idx),
        .wb_entry (wb_entry),
        .hits     (hits)
    );

endmodule

`default_nettype wire

/* hw/aste_table.sv */
`default_nettype none

`include "field_macros.svh"

module aste_table (
    input  wire                        clock,
    input  wire geom_pkg::entry_idx_t  host_addr,
    input  wire                        host_we,
    input  wire geom_pkg::aste_entry_t host_wdata,
    input  wire geom_pkg::entry_idx_t  rd_idx,
    input  wire                        wb_en,
    input  wire geom_pkg::entry_idx_t  wb_idx,
    input  wire geom_pkg::aste_entry_t wb_entry,
    output geom_pkg::aste_entry_t      host_rdata,
    output geom_pkg::aste_entry_t      rd_entry
);
    import geom_pkg::*;

    aste_entry_t mem [`FIELD_DEPTH];

    // Host port shares one address for read and write.
    // Sweep port reads for fetch and writes for collide.
    always_ff @(posedge clock) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        if (wb_en) begin
            mem[wb_idx] <= wb_entry;
        end
        host_rdata <= mem[host_addr];
        rd_entry   <= mem[rd_idx];
    end

    // The bus port holds host writes back for the whole sweep.
    assert property (@(posedge clock) !(host_we && wb_en));

endmodule

`default_nettype wire

/* hw/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    typedef logic [4:0]  wb_adr_t;
    typedef logic [15:0] wb_data_t;

    // Master to slave, held until ack.
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_data_t dat_w;
    } wb_req_t;

    // Slave to master.
    typedef struct packed {
        logic     ack;
        wb_data_t dat_r;
    } wb_rsp_t;

    // Read back at ADDR_CTRL, zero extended to the data width.
    typedef struct packed {
        logic                 busy;
        logic                 done;
        geom_pkg::hit_count_t hits;
    } field_status_t;

endpackage

`default_nettype wire

/* hw/collide_stage.sv */
`default_nettype none

module collide_stage (
    input  wire                        clock,
    input  wire                        rst,
    input  wire                        start,
    input  wire geom_pkg::stage_item_t in_item,
    input  wire geom_pkg::ship_pos_t   ship_pos,
    output logic                       wb_en,
    output geom_pkg::entry_idx_t       wb_idx,
    output geom_pkg::aste_entry_t      wb_entry,
    output geom_pkg::hit_count_t       hits
);
    import geom_pkg::*;

    localparam hit_count_t HITS_MAX = '1;

    logic        live;
    logic        hit;
    aste_entry_t result;

    assign live = in_item.valid && in_item.entry.loaded && !in_item.entry.destroyed;

    // A hit needs the moved position on the ship square.
    assign hit = live
               && (in_item.entry.x == ship_pos.x)
               && (in_item.entry.y == ship_pos.y);

    always_comb begin
        result = in_item.entry;
        if (hit) begin
            result.destroyed = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_en <= 1'b0;
            hits  <= '0;
        end else begin
            wb_en <= in_item.valid;
            if (start) begin
                hits <= '0;
            end else if (hit && (hits != HITS_MAX)) begin
                hits <= hits + hit_count_t'(1);
            end
        end
    end

    // Every valid item goes back, moved or not.
    always_ff @(posedge clock) begin
        wb_idx   <= in_item.idx;
        wb_entry <= result;
    end

endmodule

`default_nettype wire

/* hw/field_macros.svh */
`ifndef FIELD_MACROS_SVH
`define FIELD_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Number of asteroid entries in the table.
`define FIELD_DEPTH 16

// Width of one grid coordinate, the grid wraps at 2**COOR_W.
`define COOR_W 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map word addresses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Words 0 to FIELD_DEPTH-1 map the table entries.
`define ADDR_SHIP 16

// Write bit 0 to start a sweep, read for status.
`define ADDR_CTRL 17

`endif

/* hw/geom_pkg.sv */
`default_nettype none

`include "field_macros.svh"

package geom_pkg;

    typedef logic [`COOR_W-1:0] coor_t;
    typedef logic [$clog2(`FIELD_DEPTH)-1:0] entry_idx_t;
    typedef logic [4:0] hit_count_t;

    // One step per sweep along a single axis.
    typedef enum logic [1:0] {
        MOVE_X_INC = 2'b00,
        MOVE_X_DEC = 2'b01,
        MOVE_Y_INC = 2'b10,
        MOVE_Y_DEC = 2'b11
    } move_op_t;

    // Table word, the bus sees it in the low 12 data bits.
    typedef struct packed {
        logic     loaded;
        logic     destroyed;
        coor_t    x;
        coor_t    y;
        move_op_t op;
    } aste_entry_t;

    // Item handed from one sweep stage to the next.
    typedef struct packed {
        logic        valid;
        entry_idx_t  idx;
        aste_entry_t entry;
    } stage_item_t;

    typedef struct packed {
        coor_t x;
        coor_t y;
    } ship_pos_t;

endpackage

`default_nettype wire

/* hw/move_stage.sv */
`default_nettype none

module move_stage (
    input  wire                        clock,
    input  wire                        rst,
    input  wire geom_pkg::stage_item_t in_item,
    input  wire geom_pkg::aste_entry_t in_entry,
    output geom_pkg::stage_item_t      out_item
);
    import geom_pkg::*;

    stage_item_t merged;
    aste_entry_t moved;
    logic        live;
    logic        out_valid;
    entry_idx_t  out_idx;
    aste_entry_t out_entry;

    // Table data arrives one cycle after the index was issued.
    always_comb begin
        merged       = in_item;
        merged.entry = in_entry;
    end

    assign live = merged.valid && merged.entry.loaded && !merged.entry.destroyed;

    // Coordinates wrap at the grid edge.
    always_comb begin
        moved = merged.entry;
        if (live) begin
            case (merged.entry.op)
                MOVE_X_INC: moved.x = merged.entry.x + coor_t'(1);
                MOVE_X_DEC: moved.x = merged.entry.x - coor_t'(1);
                MOVE_Y_INC: moved.y = merged.entry.y + coor_t'(1);
                MOVE_Y_DEC: moved.y = merged.entry.y - coor_t'(1);
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= merged.valid;
        end
    end

    always_ff @(posedge clock) begin
        out_idx   <= merged.idx;
        out_entry <= moved;
    end

    assign out_item = '{valid: out_valid, idx: out_idx, entry: out_entry};

endmodule

`default_nettype wire

/* hw/sweep_fetch.sv */
`default_nettype none

`include "field_macros.svh"

module sweep_fetch (
    input  wire                    clock,
    input  wire                    rst,
    input  wire                    start,
    output geom_pkg::entry_idx_t   rd_idx,
    output geom_pkg::stage_item_t  fetch_item,
    output logic                   busy,
    output logic                   done
);
    import geom_pkg::*;

    localparam entry_idx_t LAST_IDX = entry_idx_t'(`FIELD_DEPTH - 1);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } state_t;

    state_t     state;
    entry_idx_t cnt;
    logic [1:0] drain_cnt;
    logic       item_valid;
    entry_idx_t item_idx;

    assign rd_idx = cnt;

    // Entry half is filled by move from the table read data.
    assign fetch_item = '{valid: item_valid, idx: item_idx, entry: '0};

    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= IDLE;
            cnt        <= '0;
            drain_cnt  <= '0;
            item_valid <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            item_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= FETCH;
                        cnt   <= '0;
                        busy  <= 1'b1;
                        done  <= 1'b0;
                    end
                end
                FETCH: begin
                    item_valid <= 1'b1;
                    cnt        <= cnt + entry_idx_t'(1);
                    if (cnt == LAST_IDX) begin
                        state     <= DRAIN;
                        drain_cnt <= 2'd2;
                    end
                end
                DRAIN: begin
                    // Fetch, move and collide registers still hold items.
                    if (drain_cnt == 2'd0) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt - 2'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == FETCH) begin
            item_idx <= cnt;
        end
    end

    // The bus port only lets a control write through once busy is low.
    assert property (@(posedge clock) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

/* hw/wb_field_port.sv */
`default_nettype none

`include "field_macros.svh"

module wb_field_port (
    input  wire                        clock,
    input  wire                        rst,
    input  wire bus_pkg::wb_req_t      wb_req,
    input  wire geom_pkg::aste_entry_t host_rdata,
    input  wire                        busy,
    input  wire                        done,
    input  wire geom_pkg::hit_count_t  hits,
    output bus_pkg::wb_rsp_t           wb_rsp,
    output geom_pkg::entry_idx_t       host_addr,
    output logic                       host_we,
    output geom_pkg::aste_entry_t      host_wdata,
    output logic                       start,
    output geom_pkg::ship_pos_t        ship_pos
);
    import geom_pkg::*;
    import bus_pkg::*;

    localparam int ENTRY_W  = $bits(aste_entry_t);
    localparam int SHIP_W   = $bits(ship_pos_t);
    localparam int STATUS_W = $bits(field_status_t);
    localparam int IDX_W    = $bits(entry_idx_t);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ACK
    } state_t;

    state_t        state;
    ship_pos_t     ship_reg;
    logic          req;
    logic          is_table;
    logic          is_ship;
    logic          is_ctrl;
    logic          stall;
    logic          wr_ack;
    field_status_t status;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign req      = wb_req.cyc && wb_req.stb;
    assign is_table = wb_req.adr < wb_adr_t'(`FIELD_DEPTH);
    assign is_ship  = wb_req.adr == wb_adr_t'(`ADDR_SHIP);
    assign is_ctrl  = wb_req.adr == wb_adr_t'(`ADDR_CTRL);

    // Only the status read gets through while a sweep is running.
    assign stall  = busy && !(is_ctrl && !wb_req.we);
    assign wr_ack = (state == ACK) && wb_req.we;

    assign host_addr  = wb_req.adr[IDX_W-1:0];
    assign host_wdata = wb_req.dat_w[ENTRY_W-1:0];
    assign host_we    = wr_ack && is_table;
    assign start      = wr_ack && is_ctrl && wb_req.dat_w[0];
    assign ship_pos   = ship_reg;
    assign status     = '{busy: busy, done: done, hits: hits};

    // WAIT gives the table one cycle for its registered read.
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (!req) begin
                        state <= IDLE;
                    end else if (!stall) begin
                        state <= ACK;
                    end
                end
                ACK:     state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ship_reg <= '0;
        end else if (wr_ack && is_ship) begin
            ship_reg <= wb_req.dat_w[SHIP_W-1:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        wb_rsp     = '0;
        wb_rsp.ack = (state == ACK);
        if ((state == ACK) && !wb_req.we) begin
            if (is_table) begin
                wb_rsp.dat_r[ENTRY_W-1:0] = host_rdata;
            end else if (is_ship) begin
                wb_rsp.dat_r[SHIP_W-1:0] = ship_reg;
            end else if (is_ctrl) begin
                wb_rsp.dat_r[STATUS_W-1:0] = status;
            end
        end
    end

    assert property (@(posedge clock) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack);

    // Table and ship accesses never complete inside a sweep.
    assert property (@(posedge clock) disable iff (rst)
        (wb_rsp.ack && !is_ctrl) |-> !busy);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the output for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_aste_field -f build.f \
    && ./obj_dir/Vtb_aste_field | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verification/field_model.sv */
`default_nettype none

`include "field_macros.svh"

package field_model;

    import geom_pkg::*;
    import bus_pkg::*;

    localparam int GRID = 1 << `COOR_W;

    // Expected table, ship and sweep results.
    aste_entry_t exp_table [`FIELD_DEPTH];
    ship_pos_t   exp_ship;
    int          exp_hits;
    logic        exp_done;

    function automatic void reset_field();
        exp_ship = '0;
        exp_hits = 0;
        exp_done = 1'b0;
    endfunction

    // Moves a coordinate by delta on the wrapping grid.
    function automatic coor_t wrap_step(coor_t c, int delta);
        int v;
        v = (int'(c) + delta + GRID) % GRID;
        return coor_t'(v);
    endfunction

    function automatic aste_entry_t step_entry(aste_entry_t e);
        aste_entry_t m;
        m = e;
        case (e.op)
            MOVE_X_INC: m.x = wrap_step(e.x, 1);
            MOVE_X_DEC: m.x = wrap_step(e.x, -1);
            MOVE_Y_INC: m.y = wrap_step(e.y, 1);
            default:    m.y = wrap_step(e.y, -1);
        endcase
        return m;
    endfunction

    // One full sweep, live entries move and may land on the ship.
    function automatic void run_sweep_rules();
        aste_entry_t e;
        exp_hits = 0;
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            e = exp_table[i];
            if (e.loaded && !e.destroyed) begin
                e = step_entry(e);
                if ((e.x == exp_ship.x) && (e.y == exp_ship.y)) begin
                    e.destroyed = 1'b1;
                    exp_hits++;
                end
            end
            exp_table[i] = e;
        end
        exp_done = 1'b1;
    endfunction

    function automatic field_status_t expected_status();
        field_status_t s;
        s.busy = 1'b0;
        s.done = exp_done;
        s.hits = hit_count_t'((exp_hits > 31) ? 31 : exp_hits);
        return s;
    endfunction

endpackage

`default_nettype wire

/* verification/tb_aste_field.sv */
`default_nettype none

`include "field_macros.svh"

module tb_aste_field;
    timeunit 1ns;
    timeprecision 1ps;

    import geom_pkg::*;
    import bus_pkg::*;
    import field_model::*;

    localparam int ENTRY_W    = $bits(aste_entry_t);
    localparam int SHIP_W     = $bits(ship_pos_t);
    localparam int STATUS_W   = $bits(field_status_t);
    localparam int ACK_LIMIT  = 200;
    localparam int POLL_LIMIT = 50;

    // A sweep holds busy for 19 cycles.
    localparam int BUSY_CYCLES = 19;

    // Planned bus accesses per scenario are 2, 34, 35, 55, 36 and 396, status polls aside.
    localparam int N_ACCESS        = 558;
    localparam int N_SWEEP         = 24;
    localparam int WATCHDOG_CYCLES = N_ACCESS * 200 + N_SWEEP * 50;

    logic    clock;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    int      last_wait;
    int      test_errors;
    int      pass_count;
    int      fail_count;

    aste_field_top u_aste_field_top (
        .clock  (clock),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone master.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Request held from a rising edge until ack is seen at a falling edge.
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_data_t dat_w,
                             output wb_data_t dat_r);
        int waited;
        waited = 0;
        @(posedge clock);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat_w};
        do begin
            @(negedge clock);
            waited++;
        end while (!wb_rsp.ack && (waited < ACK_LIMIT));
        last_wait = waited;
        if (wb_rsp.ack) begin
            dat_r = wb_rsp.dat_r;
        end else begin
            $display("Timeout: no ack within %0d cycles for address %0d", ACK_LIMIT, adr);
            test_errors++;
            dat_r = '0;
        end
        @(posedge clock);
        wb_req <= '0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare_entry(input string what, input aste_entry_t got,
                                 input aste_entry_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_status(input string what, input field_status_t got,
                                  input field_status_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got busy %b done %b hits %0d, expected %b %b %0d",
                     $time, what, got.busy, got.done, got.hits, exp.busy, exp.done, exp.hits);
            test_errors++;
        end
    endtask

    task automatic compare_ship(input string what, input ship_pos_t got, input ship_pos_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic aste_entry_t random_entry();
        logic [31:0] r;
        r = $urandom();
        return r[ENTRY_W-1:0];
    endfunction

    // Grid edges come up often so that wrap is exercised.
    function automatic coor_t edge_coor();
        int pick;
        pick = $urandom_range(0, 2);
        if (pick == 0) begin
            return '0;
        end else if (pick == 1) begin
            return '1;
        end
        return coor_t'($urandom_range(0, GRID - 1));
    endfunction

    function automatic aste_entry_t live_entry();
        aste_entry_t e;
        e.loaded    = ($urandom_range(0, 7) != 0);
        e.destroyed = ($urandom_range(0, 7) == 0);
        e.x         = edge_coor();
        e.y         = edge_coor();
        e.op        = move_op_t'($urandom_range(0, 3));
        return e;
    endfunction

    function automatic ship_pos_t random_ship();
        ship_pos_t s;
        s.x = coor_t'($urandom_range(0, GRID - 1));
        s.y = coor_t'($urandom_range(0, GRID - 1));
        return s;
    endfunction

    // Live entry one step short of the ship along its own move.
    function automatic aste_entry_t behind_ship(ship_pos_t s, move_op_t op);
        aste_entry_t e;
        e.loaded    = 1'b1;
        e.destroyed = 1'b0;
        e.op        = op;
        e.x         = s.x;
        e.y         = s.y;
        case (op)
            MOVE_X_INC: e.x = wrap_step(s.x, -1);
            MOVE_X_DEC: e.x = wrap_step(s.x, 1);
            MOVE_Y_INC: e.y = wrap_step(s.y, -1);
            default:    e.y = wrap_step(s.y, 1);
        endcase
        return e;
    endfunction

    task automatic write_entry(input int i, input aste_entry_t e);
        wb_write(wb_adr_t'(i), {4'h0, e});
        exp_table[i] = e;
    endtask

    task automatic move_ship(input ship_pos_t s);
        wb_write(wb_adr_t'(`ADDR_SHIP), {8'h00, s});
        exp_ship = s;
    endtask

    task automatic start_sweep();
        wb_write(wb_adr_t'(`ADDR_CTRL), 16'h0001);
        run_sweep_rules();
    endtask

    task automatic wait_done();
        wb_data_t      d;
        field_status_t s;
        int            polls;
        polls = 0;
        do begin
            wb_read(wb_adr_t'(`ADDR_CTRL), d);
            s = d[STATUS_W-1:0];
            polls++;
        end while (!s.done && (polls < POLL_LIMIT));
        if (!s.done) begin
            $display("Timeout: sweep did not report done after %0d status reads", POLL_LIMIT);
            test_errors++;
        end
    endtask

    // Status and every table entry against the model.
    task automatic verify_field(input string tag);
        wb_data_t d;
        wb_read(wb_adr_t'(`ADDR_CTRL), d);
        compare_status({tag, " status"}, d[STATUS_W-1:0], expected_status());
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            wb_read(wb_adr_t'(i), d);
            compare_entry($sformatf("%s entry %0d", tag, i), d[ENTRY_W-1:0], exp_table[i]);
        end
    endtask

    task automatic new_test();
        test_errors = 0;
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scenarios.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_state();
        wb_data_t d;
        new_test();
        wb_read(wb_adr_t'(`ADDR_CTRL), d);
        compare_status("status after reset", d[STATUS_W-1:0], expected_status());
        wb_read(wb_adr_t'(`ADDR_SHIP), d);
        compare_ship("ship after reset", d[SHIP_W-1:0], '0);
        report_test("reset values");
    endtask

    task automatic entry_readback();
        wb_data_t d;
        new_test();
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            write_entry(i, random_entry());
        end
        move_ship(random_ship());
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            wb_read(wb_adr_t'(i), d);
            compare_entry($sformatf("readback entry %0d", i), d[ENTRY_W-1:0], exp_table[i]);
        end
        wb_read(wb_adr_t'(`ADDR_SHIP), d);
        compare_ship("readback ship", d[SHIP_W-1:0], exp_ship);
        report_test("register readback");
    endtask

    task automatic single_sweep();
        new_test();
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            write_entry(i, live_entry());
        end
        move_ship(random_ship());
        start_sweep();
        wait_done();
        verify_field("single sweep");
        report_test("single sweep moves");
    endtask

    task automatic ship_collisions();
        aste_entry_t   e;
        ship_pos_t     s;
        field_status_t exp;
        wb_data_t      d;
        int            targets;
        int            kind;
        new_test();
        s = random_ship();
        move_ship(s);
        targets = 0;
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            kind = $urandom_range(0, 2);
            e = behind_ship(s, move_op_t'($urandom_range(0, 3)));
            if (kind == 0) begin
                targets++;
            end else if (kind == 1) begin
                // Sits on the ship and steps off it.
                e.x = s.x;
                e.y = s.y;
            end else begin
                e.destroyed = 1'b1;
            end
            write_entry(i, e);
        end
        start_sweep();
        wait_done();
        exp = '{busy: 1'b0, done: 1'b1, hits: hit_count_t'(targets)};
        wb_read(wb_adr_t'(`ADDR_CTRL), d);
        compare_status("hits against targets", d[STATUS_W-1:0], exp);
        verify_field("first collision sweep");
        move_ship(random_ship());
        start_sweep();
        wait_done();
        verify_field("second collision sweep");
        report_test("ship collisions");
    endtask

    task automatic stalled_write();
        aste_entry_t e;
        int          k;
        new_test();
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            write_entry(i, live_entry());
        end
        move_ship(random_ship());
        start_sweep();
        k = $urandom_range(0, `FIELD_DEPTH - 1);
        e = random_entry();
        wb_write(wb_adr_t'(k), {4'h0, e});
        if (last_wait < BUSY_CYCLES) begin
            $display("Table write at %0t was acked after %0d cycles, inside the sweep",
                     $time, last_wait);
            test_errors++;
        end
        exp_table[k] = e;
        wait_done();
        verify_field("write during sweep");
        report_test("write during sweep");
    endtask

    task automatic random_sweeps();
        new_test();
        for (int i = 0; i < `FIELD_DEPTH; i++) begin
            write_entry(i, live_entry());
        end
        for (int n = 0; n < 20; n++) begin
            move_ship(random_ship());
            start_sweep();
            wait_done();
            verify_field($sformatf("sweep %0d", n));
        end
        report_test("back to back sweeps");
    endtask

    initial begin
        rst         = 1'b1;
        wb_req      = '0;
        last_wait   = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        void'($urandom(75));
        reset_field();
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        reset_state();
        entry_readback();
        single_sweep();
        ship_collisions();
        stalled_write();
        random_sweeps();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
